// File: build.f
+incdir+hw
hw/pinmux_pkg.sv
hw/pinmux_ctrl_reg.sv
hw/pinmux_pad_drive.sv
hw/pinmux_pad_sample.sv
hw/pinmux_top.sv
tests/tb_pinmux.sv

// File: run.sh
#!/bin/sh
# Compile the pin multiplexer testbench with Verilator and run it.
# The run passes only if the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_pinmux \
    -o sim_pinmux \
    && ./obj_dir/sim_pinmux | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/tb_pinmux.sv
/*
 Testbench for the pin multiplexer. It drives register traffic and random peripheral
 and pad values, and checks readback, pad outputs and peripheral samples against a model.
 */
`include "pinmux_config.svh"

module tb_pinmux;

    // Stimulus runs a little over 900 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // Signal codes of the pad map where GPIO k uses code k
    localparam int CODE_UART_TX = 16;
    localparam int CODE_UART_RX = 19;
    localparam int CODE_I2C_SCL = 22;
    localparam int CODE_I2C_SDA = 24;
    localparam int CODE_SPI     = 26;

    // Pads that share one peripheral signal to exercise lower-pad priority
    localparam logic [31:0] PRIO_WORDS [5] = '{
        32'h0000_0041,      // pads 0 and 3 on UART0 TX
        32'h0000_0208,      // pads 1 and 4 on UART1 RX
        32'h0009_9000,      // SCL0 on pads 6/8 and SDA1 on pads 7/9
        32'h5550_0451,      // all SPI plus two UART TX pairs
        32'hFFFF_FFFF       // every pad on ALT3
    };

    logic                           clk_i;
    logic                           rst_n_i;
    pinmux_pkg::reg_req_t           req;
    logic [`PINMUX_REG_W-1:0]       rdata;
    pinmux_pkg::periph_drive_t      drive;
    pinmux_pkg::periph_sample_t     sample;
    logic [`PINMUX_PAD_NUM-1:0]     pad_in;
    logic [`PINMUX_PAD_NUM-1:0]     pad_val;
    logic [`PINMUX_PAD_NUM-1:0]     pad_oe;

    pinmux_pkg::ctrl_word_u         shadow;
    int                             errors = 0;
    int                             checks = 0;
    int                             cycles = 0;

    pinmux_top u_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .reg_req_i      (req),
        .reg_rdata_o    (rdata),
        .drive_i        (drive),
        .sample_o       (sample),
        .io_val_i       (pad_in),
        .io_val_o       (pad_val),
        .io_oe_o        (pad_oe)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("test timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Read data holds its value between read strobes
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !req.re |=> $stable(rdata))
    else begin
        errors++;
        $display("mismatch at %0t: read data changed without a read strobe", $time);
    end

    // Peripheral signal that pad k carries under a given select
    function automatic int pad_code(input int k, input pinmux_pkg::pad_sel_e sel);
        int code;
        code = k;
        if (k < `PINMUX_I2C_PAD_LO) begin
            if (sel == pinmux_pkg::SEL_ALT1) code = CODE_UART_TX + k % `PINMUX_UART_NUM;
            if (sel == pinmux_pkg::SEL_ALT2) code = CODE_UART_RX + k % `PINMUX_UART_NUM;
        end else if (k < `PINMUX_SPI_PAD_LO) begin
            if (sel == pinmux_pkg::SEL_ALT1) code = CODE_I2C_SCL + k % `PINMUX_I2C_NUM;
            if (sel == pinmux_pkg::SEL_ALT2) code = CODE_I2C_SDA + k % `PINMUX_I2C_NUM;
        end else if (sel == pinmux_pkg::SEL_ALT1) begin
            code = CODE_SPI + k - `PINMUX_SPI_PAD_LO;
        end
        return code;
    endfunction

    // Expected pad values in the upper half and output enables in the lower half
    function automatic logic [31:0] expect_pads(input pinmux_pkg::ctrl_word_u w,
                                                input pinmux_pkg::periph_drive_t drv);
        pinmux_pkg::pin_drive_t src [32];
        pinmux_pkg::pin_drive_t pick;
        logic [31:0]            res;
        for (int i = 0; i < 16; i++) src[i] = drv.gpio[i];
        for (int i = 0; i < 3; i++) begin
            src[CODE_UART_TX + i] = drv.uart_tx[i];
            src[CODE_UART_RX + i] = drv.uart_rx[i];
        end
        for (int i = 0; i < 2; i++) begin
            src[CODE_I2C_SCL + i] = drv.i2c_scl[i];
            src[CODE_I2C_SDA + i] = drv.i2c_sda[i];
        end
        src[CODE_SPI]     = drv.spi_clk;
        src[CODE_SPI + 1] = drv.spi_ss;
        for (int i = 0; i < 4; i++) src[CODE_SPI + 2 + i] = drv.spi_dq[i];
        res = '0;
        for (int k = 0; k < 16; k++) begin
            pick        = src[pad_code(k, w.sel[k])];
            res[16 + k] = pick.val;
            res[k]      = pick.oe;
        end
        return res;
    endfunction

    function automatic pinmux_pkg::periph_sample_t expect_sample(
            input pinmux_pkg::ctrl_word_u w, input logic [15:0] pads);
        pinmux_pkg::periph_sample_t s;
        logic [31:0]                by_code;
        logic [31:0]                claimed;
        int                         code;
        by_code = '0;
        claimed = '0;
        for (int k = 0; k < 16; k++) begin
            code = pad_code(k, w.sel[k]);
            // ALT3 drives GPIO but never samples it
            if (w.sel[k] == pinmux_pkg::SEL_GPIO) begin
                by_code[k] = pads[k];
            end else if (code >= CODE_UART_TX && !claimed[code]) begin
                claimed[code] = 1'b1;
                by_code[code] = pads[k];
            end
        end
        s.gpio    = by_code[15:0];
        s.uart_tx = by_code[18:16];
        s.uart_rx = by_code[21:19];
        s.i2c_scl = by_code[23:22];
        s.i2c_sda = by_code[25:24];
        s.spi_clk = by_code[26];
        s.spi_ss  = by_code[27];
        s.spi_dq  = by_code[31:28];
        return s;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        logic [31:0] mask;
        @(posedge clk_i);
        req.we    <= 1'b1;
        req.addr  <= addr;
        req.wdata <= data;
        req.be    <= be;
        @(posedge clk_i);
        req.we <= 1'b0;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        if (addr == `PINMUX_CTRL_ADDR) shadow.raw = (shadow.raw & ~mask) | (data & mask);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge clk_i);
        req.re   <= 1'b1;
        req.addr <= addr;
        @(posedge clk_i);
        req.re <= 1'b0;
        @(negedge clk_i);
        checks++;
        assert (rdata == expected) else begin
            errors++;
            $display("mismatch at %0t: read addr %h got %h expected %h",
                     $time, addr, rdata, expected);
        end
    endtask

    task automatic randomize_inputs();
        @(posedge clk_i);
        drive  <= pinmux_pkg::periph_drive_t'({$urandom, $urandom});
        pad_in <= 16'($urandom);
    endtask

    task automatic check_paths();
        logic [31:0]                exp_pads;
        pinmux_pkg::periph_sample_t exp_smp;
        @(negedge clk_i);
        exp_pads = expect_pads(shadow, drive);
        exp_smp  = expect_sample(shadow, pad_in);
        checks += 2;
        assert ({pad_val, pad_oe} == exp_pads) else begin
            errors++;
            $display("mismatch at %0t: ctrl %h pad val/oe %h expected %h",
                     $time, shadow.raw, {pad_val, pad_oe}, exp_pads);
        end
        assert (sample == exp_smp) else begin
            errors++;
            $display("mismatch at %0t: ctrl %h pads %h sample %h expected %h",
                     $time, shadow.raw, pad_in, sample, exp_smp);
        end
    endtask

    // Every alternate input idle as after reset
    task automatic check_alt_idle();
        pinmux_pkg::periph_sample_t alt;
        alt      = sample;
        alt.gpio = '0;
        checks++;
        assert (alt == '0) else begin
            errors++;
            $display("mismatch at %0t: alternate samples %h after reset", $time, alt);
        end
    endtask

    initial begin
        logic [31:0] addr;

        void'($urandom(32'h19c3));
        rst_n_i    = 1'b0;
        req        = '0;
        drive      = '0;
        pad_in     = '0;
        shadow.raw = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Reset state
        randomize_inputs();
        bus_read(`PINMUX_CTRL_ADDR, 32'h0);
        check_paths();
        check_alt_idle();

        // Byte-enable writes with readback
        repeat (40) begin
            bus_write(`PINMUX_CTRL_ADDR, $urandom, 4'($urandom));
            bus_read(`PINMUX_CTRL_ADDR, shadow.raw);
        end

        // Unmapped addresses
        repeat (16) begin
            addr = $urandom | 32'h4;
            bus_write(addr, $urandom, 4'hf);
            bus_read(addr, 32'h0);
            bus_read(`PINMUX_CTRL_ADDR, shadow.raw);
        end

        // Output routing over random selects
        repeat (200) begin
            bus_write(`PINMUX_CTRL_ADDR, $urandom, 4'hf);
            randomize_inputs();
            check_paths();
        end

        // Input routing where pads contend for one signal
        foreach (PRIO_WORDS[i]) begin
            bus_write(`PINMUX_CTRL_ADDR, PRIO_WORDS[i], 4'hf);
            repeat (6) begin
                randomize_inputs();
                check_paths();
            end
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hw/pinmux_top.sv
/*
 Pin multiplexer top level. The control register feeds the pad drive path
 and the pad sample path side by side.
 */
`include "pinmux_config.svh"

module pinmux_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Register bus
    input  pinmux_pkg::reg_req_t            reg_req_i,
    output logic [`PINMUX_REG_W-1:0]        reg_rdata_o,

    // Peripheral side
    input  pinmux_pkg::periph_drive_t       drive_i,
    output pinmux_pkg::periph_sample_t      sample_o,

    // Pad side
    input  logic [`PINMUX_PAD_NUM-1:0]      io_val_i,
    output logic [`PINMUX_PAD_NUM-1:0]      io_val_o,
    output logic [`PINMUX_PAD_NUM-1:0]      io_oe_o
);

    pinmux_pkg::ctrl_word_u ctrl;

    pinmux_ctrl_reg u_ctrl_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (reg_req_i),
        .rdata_o    (reg_rdata_o),
        .ctrl_o     (ctrl)
    );

    pinmux_pad_drive u_pad_drive (
        .ctrl_i     (ctrl),
        .drive_i    (drive_i),
        .io_val_o   (io_val_o),
        .io_oe_o    (io_oe_o)
    );

    pinmux_pad_sample u_pad_sample (
        .ctrl_i     (ctrl),
        .io_val_i   (io_val_i),
        .sample_o   (sample_o)
    );

endmodule

// File: hw/pinmux_pad_sample.sv
/*
 Input side of the pin multiplexer. Each peripheral input takes the value of
 the lowest pad that selects it and reads zero when no pad does.
 */
`include "pinmux_config.svh"

module pinmux_pad_sample (
    input  pinmux_pkg::ctrl_word_u          ctrl_i,
    input  logic [`PINMUX_PAD_NUM-1:0]      io_val_i,

    output pinmux_pkg::periph_sample_t      sample_o
);

    // Set once a lower pad has claimed the input
    logic [`PINMUX_UART_NUM-1:0]    tx_hit;
    logic [`PINMUX_UART_NUM-1:0]    rx_hit;
    logic [`PINMUX_I2C_NUM-1:0]     scl_hit;
    logic [`PINMUX_I2C_NUM-1:0]     sda_hit;
    logic [`PINMUX_SPI_PAD_NUM-1:0] spi_smp;

    always_comb begin
        int u;
        int c;

        sample_o = '0;
        tx_hit   = '0;
        rx_hit   = '0;
        scl_hit  = '0;
        sda_hit  = '0;
        spi_smp  = '0;

        // GPIO sees its pad only in the primary select, not under ALT3
        for (int k = 0; k < `PINMUX_PAD_NUM; k++) begin
            sample_o.gpio[k] = (ctrl_i.sel[k] == pinmux_pkg::SEL_GPIO) ? io_val_i[k] : 1'b0;
        end

        // Walk upward so the first match wins
        for (int k = `PINMUX_UART_PAD_LO; k < `PINMUX_I2C_PAD_LO; k++) begin
            u = (k - `PINMUX_UART_PAD_LO) % `PINMUX_UART_NUM;
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT1 && !tx_hit[u]) begin
                sample_o.uart_tx[u] = io_val_i[k];
                tx_hit[u]           = 1'b1;
            end
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT2 && !rx_hit[u]) begin
                sample_o.uart_rx[u] = io_val_i[k];
                rx_hit[u]           = 1'b1;
            end
        end

        for (int k = `PINMUX_I2C_PAD_LO; k < `PINMUX_SPI_PAD_LO; k++) begin
            c = (k - `PINMUX_I2C_PAD_LO) % `PINMUX_I2C_NUM;
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT1 && !scl_hit[c]) begin
                sample_o.i2c_scl[c] = io_val_i[k];
                scl_hit[c]          = 1'b1;
            end
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT2 && !sda_hit[c]) begin
                sample_o.i2c_sda[c] = io_val_i[k];
                sda_hit[c]          = 1'b1;
            end
        end

        // One pad per SPI signal, no contention
        for (int k = `PINMUX_SPI_PAD_LO; k < `PINMUX_PAD_NUM; k++) begin
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT1) begin
                spi_smp[k - `PINMUX_SPI_PAD_LO] = io_val_i[k];
            end
        end
        {sample_o.spi_dq, sample_o.spi_ss, sample_o.spi_clk} = spi_smp;
    end

endmodule

// File: hw/pinmux_pad_drive.sv
/*
 Output side of the pin multiplexer. Each pad takes value and output enable
 from the peripheral its select field names, GPIO being the fallback.
 */
`include "pinmux_config.svh"

module pinmux_pad_drive (
    input  pinmux_pkg::ctrl_word_u          ctrl_i,
    input  pinmux_pkg::periph_drive_t       drive_i,

    output logic [`PINMUX_PAD_NUM-1:0]      io_val_o,
    output logic [`PINMUX_PAD_NUM-1:0]      io_oe_o
);

    pinmux_pkg::pin_drive_t [`PINMUX_PAD_NUM-1:0]       pad_drv;
    pinmux_pkg::pin_drive_t [`PINMUX_SPI_PAD_NUM-1:0]   spi_alt;

    // SPI pads in order clk, ss, dq0..dq3
    assign spi_alt = {drive_i.spi_dq, drive_i.spi_ss, drive_i.spi_clk};

    always_comb begin
        // GPIO unless an alternate function claims the pad
        pad_drv = drive_i.gpio;

        // UART pads, TX on ALT1 and RX on ALT2
        for (int k = `PINMUX_UART_PAD_LO; k < `PINMUX_I2C_PAD_LO; k++) begin
            case (ctrl_i.sel[k])
                pinmux_pkg::SEL_ALT1: begin
                    pad_drv[k] = drive_i.uart_tx[(k - `PINMUX_UART_PAD_LO) % `PINMUX_UART_NUM];
                end
                pinmux_pkg::SEL_ALT2: begin
                    pad_drv[k] = drive_i.uart_rx[(k - `PINMUX_UART_PAD_LO) % `PINMUX_UART_NUM];
                end
                default: ;
            endcase
        end

        // I2C pads, SCL on ALT1 and SDA on ALT2
        for (int k = `PINMUX_I2C_PAD_LO; k < `PINMUX_SPI_PAD_LO; k++) begin
            case (ctrl_i.sel[k])
                pinmux_pkg::SEL_ALT1: begin
                    pad_drv[k] = drive_i.i2c_scl[(k - `PINMUX_I2C_PAD_LO) % `PINMUX_I2C_NUM];
                end
                pinmux_pkg::SEL_ALT2: begin
                    pad_drv[k] = drive_i.i2c_sda[(k - `PINMUX_I2C_PAD_LO) % `PINMUX_I2C_NUM];
                end
                default: ;
            endcase
        end

        // SPI pads have a single alternate
        for (int k = `PINMUX_SPI_PAD_LO; k < `PINMUX_PAD_NUM; k++) begin
            if (ctrl_i.sel[k] == pinmux_pkg::SEL_ALT1) begin
                pad_drv[k] = spi_alt[k - `PINMUX_SPI_PAD_LO];
            end
        end
    end

    // Split the pairs onto the pad bus
    always_comb begin
        for (int k = 0; k < `PINMUX_PAD_NUM; k++) begin
            io_val_o[k] = pad_drv[k].val;
            io_oe_o[k]  = pad_drv[k].oe;
        end
    end

endmodule

// File: hw/pinmux_ctrl_reg.sv
/*
 Pad select register with byte-enable writes and registered readback.
 Only the control address is mapped, all others read as zero.
 */
`include "pinmux_config.svh"

module pinmux_ctrl_reg (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  pinmux_pkg::reg_req_t        req_i,
    output logic [`PINMUX_REG_W-1:0]    rdata_o,

    output pinmux_pkg::ctrl_word_u      ctrl_o
);

    pinmux_pkg::ctrl_word_u ctrl_q;
    pinmux_pkg::ctrl_word_u ctrl_d;
    logic                   addr_hit;

    assign addr_hit = (req_i.addr == `PINMUX_CTRL_ADDR);

    // Merge write data into the current word lane by lane
    always_comb begin
        ctrl_d = ctrl_q;
        for (int b = 0; b < `PINMUX_BE_W; b++) begin
            if (req_i.be[b]) begin
                ctrl_d.raw[b*8 +: 8] = req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q.raw <= '0;
        end else if (req_i.we && addr_hit) begin
            ctrl_q <= ctrl_d;
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i.re) begin
            rdata_o <= addr_hit ? ctrl_q.raw : '0;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// File: hw/pinmux_pkg.sv
/*
 Shared types of the pin multiplexer: pad selects, the control word,
 peripheral drive and sample bundles and the register request.
 */
`include "pinmux_config.svh"

package pinmux_pkg;

    // Function select of one pad
    typedef enum logic [`PINMUX_SEL_W-1:0] {
        SEL_GPIO = 0,
        SEL_ALT1 = 1,
        SEL_ALT2 = 2,
        SEL_ALT3 = 3
    } pad_sel_e;

    // Control register, as a bus word or as per-pad selects with pad 0 lowest
    typedef union packed {
        logic [`PINMUX_REG_W-1:0]           raw;
        pad_sel_e [`PINMUX_PAD_NUM-1:0]     sel;
    } ctrl_word_u;

    // What one peripheral signal presents to a pin
    typedef struct packed {
        logic val;
        logic oe;
    } pin_drive_t;

    typedef struct packed {
        pin_drive_t [`PINMUX_PAD_NUM-1:0]       gpio;
        pin_drive_t [`PINMUX_UART_NUM-1:0]      uart_tx;
        pin_drive_t [`PINMUX_UART_NUM-1:0]      uart_rx;
        pin_drive_t [`PINMUX_I2C_NUM-1:0]       i2c_scl;
        pin_drive_t [`PINMUX_I2C_NUM-1:0]       i2c_sda;
        pin_drive_t                             spi_clk;
        pin_drive_t                             spi_ss;
        pin_drive_t [`PINMUX_SPI_DQ_NUM-1:0]    spi_dq;
    } periph_drive_t;

    // Pad values handed back to the peripherals
    typedef struct packed {
        logic [`PINMUX_PAD_NUM-1:0]     gpio;
        logic [`PINMUX_UART_NUM-1:0]    uart_tx;
        logic [`PINMUX_UART_NUM-1:0]    uart_rx;
        logic [`PINMUX_I2C_NUM-1:0]     i2c_scl;
        logic [`PINMUX_I2C_NUM-1:0]     i2c_sda;
        logic                           spi_clk;
        logic                           spi_ss;
        logic [`PINMUX_SPI_DQ_NUM-1:0]  spi_dq;
    } periph_sample_t;

    // Register bus strobes, one cycle each
    typedef struct packed {
        logic                       we;
        logic                       re;
        logic [`PINMUX_BE_W-1:0]    be;
        logic [`PINMUX_REG_W-1:0]   addr;
        logic [`PINMUX_REG_W-1:0]   wdata;
    } reg_req_t;

endpackage

// File: hw/pinmux_config.svh
/*
 Build-time sizes of the pin multiplexer, included by the package and the RTL.
 Pad group boundaries follow from the peripheral counts.
 */
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// Pads and select field
`define PINMUX_PAD_NUM      16
`define PINMUX_SEL_W        2

// Peripheral instance counts
`define PINMUX_UART_NUM     3
`define PINMUX_I2C_NUM      2
`define PINMUX_SPI_DQ_NUM   4

// Register bus
`define PINMUX_REG_W        32
`define PINMUX_BE_W         (`PINMUX_REG_W / 8)
`define PINMUX_CTRL_ADDR    32'h0000_0000

// First pad of each group, UART pairs then I2C pairs then SPI
`define PINMUX_UART_PAD_LO  0
`define PINMUX_I2C_PAD_LO   (`PINMUX_UART_PAD_LO + 2 * `PINMUX_UART_NUM)
`define PINMUX_SPI_PAD_LO   (`PINMUX_I2C_PAD_LO + 2 * `PINMUX_I2C_NUM)
`define PINMUX_SPI_PAD_NUM  (2 + `PINMUX_SPI_DQ_NUM)

`endif
